// File: Makefile
# Verilator build and run of the execute unit testbench

VERILATOR ?= verilator
TOP       ?= ex_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails on a failing run"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
+incdir+include
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_bru.sv
logic/ex_pipe.sv
logic/ex_apb_regs.sv
logic/ex_unit_top.sv
verification/ex_tb_clk.sv
verification/ex_props.sv
verification/ex_tb.sv

// File: include/ex_params.svh
/*
 Execute pipe parameters
 Widths shared by the package, the pipe and the APB register block
*/
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Datapath word
`define EX_DW      32
// Word-addressed PC, byte offset dropped
`define EX_PC_W    30
// Physical register file address
`define EX_PRF_AW  6
// Reorder buffer slot id
`define EX_ROB_AW  4
// Fetch exception code, zero is no exception
`define EX_FE_W    3
// APB register block address
`define EX_APB_AW  4

// Opcode field widths for the enums
`define EX_ALU_OPW 3
`define EX_BRU_OPW 4
`define EX_FU_W    2

`endif

// File: logic/ex_alu.sv
/*
 Integer ALU
 Logic and shift ops, add and sub taken from the pipe's shared adder
*/
`timescale 1ns/1ns
`default_nettype none

module ex_alu (
   input  ex_pkg::alu_op_e alu_op,
   input  ex_pkg::data_t   operand1,
   input  ex_pkg::data_t   operand2,
   input  ex_pkg::data_t   add_sum,
   output ex_pkg::data_t   result
);

   logic [4:0] shamt;

   // Shift amount from the low five bits
   assign shamt = operand2[4:0];

   always_comb begin
      case (alu_op)
         // Adder already set up for add or subtract
         ex_pkg::ALU_ADD,
         ex_pkg::ALU_SUB: begin
            result = add_sum;
         end
         ex_pkg::ALU_AND: begin
            result = operand1 & operand2;
         end
         ex_pkg::ALU_OR: begin
            result = operand1 | operand2;
         end
         ex_pkg::ALU_XOR: begin
            result = operand1 ^ operand2;
         end
         ex_pkg::ALU_SLL: begin
            result = operand1 << shamt;
         end
         ex_pkg::ALU_SRL: begin
            result = operand1 >> shamt;
         end
         // Sign bits shifted in
         ex_pkg::ALU_SRA: begin
            result = ex_pkg::data_t'($signed(operand1) >>> shamt);
         end
         default: begin
            result = add_sum;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: logic/ex_apb_regs.sv
/*
 APB register block
 Halt control bit and three wrapping event counters,
 cleared by any write to their address
*/
`timescale 1ns/1ns
`default_nettype none

`include "ex_params.svh"

module ex_apb_regs (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [`EX_APB_AW-1:0] paddr,
   input  ex_pkg::data_t         pwdata,
   output ex_pkg::data_t         prdata,
   output logic                  pready,
   output logic                  pslverr,
   input  ex_pkg::ex_event_t     events,
   output logic                  halt
);

   // Register map
   localparam logic [`EX_APB_AW-1:0] REG_CTRL   = 'h0;
   localparam logic [`EX_APB_AW-1:0] REG_RETIRE = 'h4;
   localparam logic [`EX_APB_AW-1:0] REG_FLS    = 'h8;
   localparam logic [`EX_APB_AW-1:0] REG_EXC    = 'hC;
   localparam int                    NCNT       = 3;

   logic            access;
   logic            addr_ok;
   logic            wr_en;
   logic [NCNT-1:0] cnt_inc;
   logic [NCNT-1:0] cnt_clr;
   ex_pkg::data_t   cnt_q [NCNT];

   // Access phase, no wait states
   assign access = psel & penable;
   assign pready = 1'b1;

   // Aligned mapped addresses only
   always_comb begin
      case (paddr)
         REG_CTRL, REG_RETIRE, REG_FLS, REG_EXC: addr_ok = 1'b1;
         default: addr_ok = 1'b0;
      endcase
   end

   assign pslverr = access & ~addr_ok;
   assign wr_en   = access & pwrite & addr_ok;

   // Counter order: retire, fls, exc
   assign cnt_inc = {events.exc, events.fls, events.retire};
   assign cnt_clr = {wr_en & (paddr == REG_EXC),
                     wr_en & (paddr == REG_FLS),
                     wr_en & (paddr == REG_RETIRE)};

   // Halt control
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         halt <= 1'b0;
      end else if (wr_en && (paddr == REG_CTRL)) begin
         halt <= pwdata[0];
      end
   end

   // Wrapping counters, clear beats increment
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NCNT; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NCNT; i++) begin
            if (cnt_clr[i]) begin
               cnt_q[i] <= '0;
            end else if (cnt_inc[i]) begin
               cnt_q[i] <= cnt_q[i] + ex_pkg::data_t'(1);
            end
         end
      end
   end

   // Read mux
   always_comb begin
      case (paddr)
         REG_CTRL:   prdata = {{(`EX_DW-1){1'b0}}, halt};
         REG_RETIRE: prdata = cnt_q[0];
         REG_FLS:    prdata = cnt_q[1];
         REG_EXC:    prdata = cnt_q[2];
         default:    prdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/ex_bru.sv
/*
 Branch unit
 Resolves branch conditions from the shared subtract, computes
 the word target and the next PC used as the link value
*/
`timescale 1ns/1ns
`default_nettype none

`include "ex_params.svh"

module ex_bru (
   input  ex_pkg::bru_op_e bru_op,
   input  ex_pkg::pc_t     pc,
   input  ex_pkg::data_t   imm,
   input  ex_pkg::data_t   operand1,
   input  ex_pkg::data_t   operand2,
   input  ex_pkg::data_t   add_sum,
   input  logic            add_carry,
   input  logic            add_overflow,
   output logic            taken,
   output ex_pkg::pc_t     tgt,
   output ex_pkg::pc_t     npc
);

   ex_pkg::pc_t   imm_w;
   ex_pkg::pc_t   br_tgt;
   ex_pkg::data_t jalr_sum;
   logic          eq;
   logic          lt;
   logic          ltu;

   // Byte immediate as a word offset
   assign imm_w  = imm[`EX_DW-1:2];
   assign br_tgt = pc + imm_w;
   assign npc    = pc + ex_pkg::pc_t'(1);

   // Register-relative target, byte sum then word address
   assign jalr_sum = operand1 + imm;

   // Compare flags
   assign eq  = (operand1 == operand2);
   // Signed less-than from sign and overflow of op1 - op2
   assign lt  = add_sum[`EX_DW-1] ^ add_overflow;
   // No carry out of the subtract means a borrow
   assign ltu = ~add_carry;

   always_comb begin
      tgt = br_tgt;
      case (bru_op)
         ex_pkg::BRU_JAL: begin
            taken = 1'b1;
         end
         ex_pkg::BRU_JALR: begin
            taken = 1'b1;
            tgt   = jalr_sum[`EX_DW-1:2];
         end
         ex_pkg::BRU_BEQ:  taken = eq;
         ex_pkg::BRU_BNE:  taken = ~eq;
         ex_pkg::BRU_BLT:  taken = lt;
         ex_pkg::BRU_BGE:  taken = ~lt;
         ex_pkg::BRU_BLTU: taken = ltu;
         ex_pkg::BRU_BGEU: taken = ~ltu;
         // Not a branch
         default: taken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/ex_pipe.sv
/*
 Execute pipe
 Shared adder, ALU and branch resolution, address generation,
 mispredict check and a flushable one-entry output stage
*/
`timescale 1ns/1ns
`default_nettype none

`include "ex_params.svh"

module ex_pipe (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              flush,
   input  logic              halt,
   input  logic              ex_valid,
   input  ex_pkg::ex_issue_t ex_issue,
   output logic              ex_ready,
   input  logic              wb_ready,
   output logic              wb_valid,
   output ex_pkg::ex_wb_t    wb,
   output ex_pkg::ex_event_t events
);

   logic           is_alu;
   logic           is_bru;
   logic           agu_en;
   logic           add_sub;
   logic           add_carry;
   logic           add_overflow;
   logic           link_sel;
   logic           bru_taken;
   logic           b_taken;
   logic           p_ce;
   logic           stage_valid;
   ex_pkg::data_t  add_b;
   ex_pkg::data_t  add_sum;
   ex_pkg::data_t  alu_result;
   ex_pkg::pc_t    b_tgt;
   ex_pkg::pc_t    npc;
   ex_pkg::ex_wb_t wb_d;
   ex_pkg::ex_wb_t wb_q;

   // Unit decode
   assign is_alu = (ex_issue.fu == ex_pkg::FU_ALU);
   assign is_bru = (ex_issue.fu == ex_pkg::FU_BRU);
   // LSU and EPU only need an address
   assign agu_en = (ex_issue.fu == ex_pkg::FU_LSU) | (ex_issue.fu == ex_pkg::FU_EPU);

   // Subtract for sub and the compare branches
   assign add_sub = (is_alu & (ex_issue.alu_op == ex_pkg::ALU_SUB)) |
                    (is_bru & (ex_issue.bru_op inside {ex_pkg::BRU_BEQ, ex_pkg::BRU_BNE,
                                                       ex_pkg::BRU_BLT, ex_pkg::BRU_BGE,
                                                       ex_pkg::BRU_BLTU, ex_pkg::BRU_BGEU}));

   // Second adder input, inverted for a subtract
   assign add_b = agu_en  ? ex_issue.imm :
                  add_sub ? ~ex_issue.operand2 : ex_issue.operand2;

   // The one adder, carry-in completes the two's complement
   assign {add_carry, add_sum} = {1'b0, ex_issue.operand1} + {1'b0, add_b} +
                                 {{`EX_DW{1'b0}}, add_sub};
   assign add_overflow = (ex_issue.operand1[`EX_DW-1] == add_b[`EX_DW-1]) &
                         (add_sum[`EX_DW-1] != ex_issue.operand1[`EX_DW-1]);

   ex_alu u_alu (
      .alu_op   (ex_issue.alu_op),
      .operand1 (ex_issue.operand1),
      .operand2 (ex_issue.operand2),
      .add_sum  (add_sum),
      .result   (alu_result)
   );

   ex_bru u_bru (
      .bru_op       (ex_issue.bru_op),
      .pc           (ex_issue.pc),
      .imm          (ex_issue.imm),
      .operand1     (ex_issue.operand1),
      .operand2     (ex_issue.operand2),
      .add_sum      (add_sum),
      .add_carry    (add_carry),
      .add_overflow (add_overflow),
      .taken        (bru_taken),
      .tgt          (b_tgt),
      .npc          (npc)
   );

   // Only a branch op can be taken
   assign b_taken  = is_bru & bru_taken;
   assign link_sel = is_bru & (ex_issue.bru_op inside {ex_pkg::BRU_JAL, ex_pkg::BRU_JALR});

   // Next writeback fields
   always_comb begin
      wb_d.rob_id  = ex_issue.rob_id;
      // LSU and EPU results come later from commit
      wb_d.prf_we  = (is_alu | is_bru) & ex_issue.prd_we;
      wb_d.prd     = ex_issue.prd;
      // Link value as byte address of the next insn
      wb_d.wdata   = link_sel ? {npc, 2'b00} : alu_result;
      // Wrong direction, or taken to the wrong place
      wb_d.fls     = (b_taken ^ ex_issue.pred_taken) |
                     (b_taken & (b_tgt != ex_issue.pred_tgt));
      wb_d.exc     = |ex_issue.fe;
      wb_d.opera   = wb_d.exc ? {{(`EX_DW-`EX_FE_W){1'b0}}, ex_issue.fe} : add_sum;
      wb_d.operb   = ex_issue.operand2;
      // Redirect PC for the flush
      wb_d.fls_tgt = b_taken ? b_tgt : npc;
   end

   // Ready when not halted and the stage drains or is empty
   assign ex_ready = ~halt & (~stage_valid | wb_ready);
   // Issue in a flush cycle is dropped
   assign p_ce     = ex_valid & ex_ready & ~flush;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stage_valid <= 1'b0;
      end else if (flush) begin
         stage_valid <= 1'b0;
      end else if (p_ce) begin
         stage_valid <= 1'b1;
      end else if (wb_ready) begin
         stage_valid <= 1'b0;
      end
   end

   // Payload, held while stalled
   always_ff @(posedge clk) begin
      if (p_ce) begin
         wb_q <= wb_d;
      end
   end

   assign wb_valid = stage_valid;

   always_comb begin
      wb        = wb_q;
      // Write enable only with a valid result
      wb.prf_we = wb_q.prf_we & stage_valid;
   end

   // Event pulses on each wb transfer
   assign events.retire = stage_valid & wb_ready;
   assign events.fls    = events.retire & wb_q.fls;
   assign events.exc    = events.retire & wb_q.exc;

endmodule

`default_nettype wire

// File: logic/ex_pkg.sv
/*
 Execute pipe package
 Width typedefs, opcode enums, issue and writeback structs
*/
`default_nettype none

`include "ex_params.svh"

package ex_pkg;

   // Widths with a meaning
   typedef logic [`EX_DW-1:0]     data_t;
   typedef logic [`EX_PC_W-1:0]   pc_t;
   typedef logic [`EX_PRF_AW-1:0] prf_addr_t;
   typedef logic [`EX_ROB_AW-1:0] rob_id_t;
   typedef logic [`EX_FE_W-1:0]   fe_t;

   // Integer ALU ops
   typedef enum logic [`EX_ALU_OPW-1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA
   } alu_op_e;

   // Branch ops, NONE for non-branch micro-ops
   typedef enum logic [`EX_BRU_OPW-1:0] {
      BRU_NONE,
      BRU_JAL,
      BRU_JALR,
      BRU_BEQ,
      BRU_BNE,
      BRU_BLT,
      BRU_BGE,
      BRU_BLTU,
      BRU_BGEU
   } bru_op_e;

   // Functional unit of the micro-op
   typedef enum logic [`EX_FU_W-1:0] {
      FU_ALU,
      FU_BRU,
      FU_LSU,
      FU_EPU
   } fu_sel_e;

   // Issued micro-op from the reservation station
   typedef struct packed {
      fu_sel_e   fu;
      alu_op_e   alu_op;
      bru_op_e   bru_op;
      fe_t       fe;
      logic      pred_taken;
      pc_t       pred_tgt;
      pc_t       pc;
      data_t     imm;
      data_t     operand1;
      data_t     operand2;
      prf_addr_t prd;
      logic      prd_we;
      rob_id_t   rob_id;
   } ex_issue_t;

   // Result to writeback
   typedef struct packed {
      rob_id_t   rob_id;
      logic      prf_we;
      prf_addr_t prd;
      data_t     wdata;
      logic      fls;
      logic      exc;
      data_t     opera;
      data_t     operb;
      pc_t       fls_tgt;
   } ex_wb_t;

   // Single-cycle event pulses for the counters
   typedef struct packed {
      logic retire;
      logic fls;
      logic exc;
   } ex_event_t;

endpackage

`default_nettype wire

// File: logic/ex_unit_top.sv
/*
 Execute unit top
 Execute pipe with its APB control and event counter block
*/
`timescale 1ns/1ns
`default_nettype none

`include "ex_params.svh"

module ex_unit_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  flush,
   // Issue side
   input  logic                  ex_valid,
   input  ex_pkg::ex_issue_t     ex_issue,
   output logic                  ex_ready,
   // Writeback side
   input  logic                  wb_ready,
   output logic                  wb_valid,
   output ex_pkg::ex_wb_t        wb,
   // APB slave
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [`EX_APB_AW-1:0] paddr,
   input  ex_pkg::data_t         pwdata,
   output ex_pkg::data_t         prdata,
   output logic                  pready,
   output logic                  pslverr
);

   logic              halt;
   ex_pkg::ex_event_t events;

   ex_pipe u_pipe (
      .clk      (clk),
      .rst_n    (rst_n),
      .flush    (flush),
      .halt     (halt),
      .ex_valid (ex_valid),
      .ex_issue (ex_issue),
      .ex_ready (ex_ready),
      .wb_ready (wb_ready),
      .wb_valid (wb_valid),
      .wb       (wb),
      .events   (events)
   );

   ex_apb_regs u_regs (
      .clk     (clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .events  (events),
      .halt    (halt)
   );

endmodule

`default_nettype wire

// File: verification/ex_props.sv
/*
 Execute pipe handshake properties
 Bound into ex_pipe, checks output stability, reset state and halt
*/
`timescale 1ns/1ns
`default_nettype none

module ex_props (
   input logic           clk,
   input logic           rst_n,
   input logic           flush,
   input logic           halt,
   input logic           ex_ready,
   input logic           wb_ready,
   input logic           wb_valid,
   input ex_pkg::ex_wb_t wb
);

   // Stalled result stays put until taken or flushed
   wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (wb_valid && !wb_ready && !flush) |=> (wb_valid && $stable(wb)))
      else $error("wb changed or dropped while stalled");

   // Stage empty at the first edge out of reset
   wb_reset: assert property (@(posedge clk) $rose(rst_n) |-> !wb_valid)
      else $error("wb_valid high after reset");

   // Empty stage does not fill while halted
   halt_ready: assert property (@(posedge clk) disable iff (!rst_n)
      (halt && !wb_valid) |=> !wb_valid)
      else $error("result entered the stage while halt is set");

endmodule

bind ex_pipe ex_props u_props (
   .clk      (clk),
   .rst_n    (rst_n),
   .flush    (flush),
   .halt     (halt),
   .ex_ready (ex_ready),
   .wb_ready (wb_ready),
   .wb_valid (wb_valid),
   .wb       (wb)
);

`default_nettype wire

// File: verification/ex_tb.sv
/*
 Execute unit testbench
 Table of micro-ops with expected writeback, random back-pressure,
 flush, halt and APB counter checks
*/
`timescale 1ns/1ns
`default_nettype none

`include "ex_params.svh"

module ex_tb;

   localparam int TIMEOUT = 2000;

   // One table row, stimulus and expected result
   typedef struct packed {
      ex_pkg::ex_issue_t iss;
      ex_pkg::ex_wb_t    exp;
   } row_t;

   logic                  clk;
   logic                  rst_n;
   logic                  flush;
   logic                  ex_valid;
   ex_pkg::ex_issue_t     ex_issue;
   logic                  ex_ready;
   logic                  wb_ready;
   logic                  wb_valid;
   ex_pkg::ex_wb_t        wb;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [`EX_APB_AW-1:0] paddr;
   ex_pkg::data_t         pwdata;
   ex_pkg::data_t         prdata;
   logic                  pready;
   logic                  pslverr;

   row_t        rows [$];
   logic [31:0] lcg_state;

   ex_tb_clk u_clk (
      .clk (clk)
   );

   ex_unit_top DUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .flush    (flush),
      .ex_valid (ex_valid),
      .ex_issue (ex_issue),
      .ex_ready (ex_ready),
      .wb_ready (wb_ready),
      .wb_valid (wb_valid),
      .wb       (wb),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr)
   );

   task automatic stop_run();
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic timed_out(input string what);
      $display("Timeout while waiting for %s at %0t ns", what, $time);
      stop_run();
   endtask

   task automatic check_wb(input ex_pkg::ex_wb_t got, input ex_pkg::ex_wb_t exp,
                           input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns %s: wb %h, expected %h", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_data(input ex_pkg::data_t got, input ex_pkg::data_t exp,
                             input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns %s: %h, expected %h", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns %s: %b, expected %b", $time, what, got, exp);
         stop_run();
      end
   endtask

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Row fields that follow from the row number
   function automatic ex_pkg::ex_issue_t base_issue(input ex_pkg::fu_sel_e fu,
      input ex_pkg::data_t o1, input ex_pkg::data_t o2, input ex_pkg::data_t imm);
      ex_pkg::ex_issue_t s;
      s          = '0;
      s.fu       = fu;
      s.alu_op   = ex_pkg::ALU_ADD;
      s.bru_op   = ex_pkg::BRU_NONE;
      s.pc       = ex_pkg::pc_t'(30'h400 + rows.size());
      s.imm      = imm;
      s.operand1 = o1;
      s.operand2 = o2;
      s.prd      = ex_pkg::prf_addr_t'(rows.size() + 1);
      s.prd_we   = 1'b1;
      s.rob_id   = ex_pkg::rob_id_t'(rows.size());
      return s;
   endfunction

   // Not a branch, no exception, redirect is the next PC
   function automatic ex_pkg::ex_wb_t base_wb(input ex_pkg::ex_issue_t s,
      input ex_pkg::data_t wdata, input ex_pkg::data_t sum);
      ex_pkg::ex_wb_t w;
      w.rob_id  = s.rob_id;
      w.prf_we  = s.prd_we;
      w.prd     = s.prd;
      w.wdata   = wdata;
      w.fls     = 1'b0;
      w.exc     = 1'b0;
      w.opera   = sum;
      w.operb   = s.operand2;
      w.fls_tgt = s.pc + ex_pkg::pc_t'(1);
      return w;
   endfunction

   task automatic push_row(input ex_pkg::ex_issue_t s, input ex_pkg::ex_wb_t w);
      row_t r;
      r.iss = s;
      r.exp = w;
      rows.push_back(r);
   endtask

   // sum is the expected adder output
   task automatic add_alu(input ex_pkg::alu_op_e op, input ex_pkg::data_t o1,
      input ex_pkg::data_t o2, input logic we, input ex_pkg::data_t res,
      input ex_pkg::data_t sum);
      ex_pkg::ex_issue_t s;
      s        = base_issue(ex_pkg::FU_ALU, o1, o2, '0);
      s.alu_op = op;
      s.prd_we = we;
      push_row(s, base_wb(s, res, sum));
   endtask

   task automatic add_br(input ex_pkg::bru_op_e op, input ex_pkg::data_t o1,
      input ex_pkg::data_t o2, input ex_pkg::data_t imm, input logic taken,
      input logic pt, input logic tgt_ok, input ex_pkg::data_t sum);
      ex_pkg::ex_issue_t s;
      ex_pkg::ex_wb_t    w;
      ex_pkg::data_t     rsum;
      ex_pkg::pc_t       tgt;
      ex_pkg::pc_t       npc;
      logic              link;
      s      = base_issue(ex_pkg::FU_BRU, o1, o2, imm);
      s.bru_op = op;
      link     = (op == ex_pkg::BRU_JAL) || (op == ex_pkg::BRU_JALR);
      s.prd_we = link;
      npc      = s.pc + ex_pkg::pc_t'(1);
      // jalr goes register relative, the rest PC relative in words
      rsum     = o1 + imm;
      tgt      = (op == ex_pkg::BRU_JALR) ? rsum[31:2] : s.pc + imm[31:2];
      s.pred_taken = pt;
      s.pred_tgt   = tgt_ok ? tgt : tgt + ex_pkg::pc_t'(9);
      w         = base_wb(s, link ? {npc, 2'b00} : sum, sum);
      w.fls     = (taken != pt) || (taken && !tgt_ok);
      w.fls_tgt = taken ? tgt : npc;
      push_row(s, w);
   endtask

   // Address ops write no register, a fetch fault replaces the address
   task automatic add_mem(input ex_pkg::fu_sel_e fu, input ex_pkg::data_t o1,
      input ex_pkg::data_t imm, input ex_pkg::data_t o2, input ex_pkg::fe_t fe,
      input ex_pkg::data_t sum);
      ex_pkg::ex_issue_t s;
      ex_pkg::ex_wb_t    w;
      s        = base_issue(fu, o1, o2, imm);
      s.fe     = fe;
      w        = base_wb(s, sum, (fe != '0) ? ex_pkg::data_t'(fe) : sum);
      w.prf_we = 1'b0;
      w.exc    = (fe != '0);
      push_row(s, w);
   endtask

   task automatic build_table();
      add_alu(ex_pkg::ALU_ADD, 32'h5,        32'h7,        1'b1, 32'hc,        32'hc);
      add_alu(ex_pkg::ALU_SUB, 32'h3,        32'h5,        1'b1, 32'hfffffffe, 32'hfffffffe);
      add_alu(ex_pkg::ALU_SUB, 32'h0,        32'h80000000, 1'b1, 32'h80000000, 32'h80000000);
      add_alu(ex_pkg::ALU_AND, 32'h0000ff00, 32'h00ffff00, 1'b1, 32'h0000ff00, 32'h0100fe00);
      add_alu(ex_pkg::ALU_OR,  32'hc,        32'h3,        1'b1, 32'hf,        32'hf);
      add_alu(ex_pkg::ALU_XOR, 32'hf,        32'h5,        1'b1, 32'ha,        32'h14);
      add_alu(ex_pkg::ALU_SLL, 32'h3,        32'h24,       1'b1, 32'h30,       32'h27);
      add_alu(ex_pkg::ALU_SRL, 32'h80000000, 32'h1f,       1'b1, 32'h1,        32'h8000001f);
      add_alu(ex_pkg::ALU_SRA, 32'h80000000, 32'h4,        1'b1, 32'hf8000000, 32'h80000004);
      add_alu(ex_pkg::ALU_SRA, 32'h40000000, 32'h1,        1'b1, 32'h20000000, 32'h40000001);
      // Unused destination
      add_alu(ex_pkg::ALU_ADD, 32'h1,        32'h1,        1'b0, 32'h2,        32'h2);
      // Jumps, with correct, missed and wrong-target predictions
      add_br(ex_pkg::BRU_JAL,  32'h0, 32'h0, 32'h10,       1'b1, 1'b1, 1'b1, 32'h0);
      add_br(ex_pkg::BRU_JAL,  32'h0, 32'h0, 32'hfffffff0, 1'b1, 1'b0, 1'b1, 32'h0);
      add_br(ex_pkg::BRU_JALR, 32'h1000, 32'h5, 32'h20,    1'b1, 1'b1, 1'b0, 32'h1005);
      add_br(ex_pkg::BRU_JALR, 32'h3000, 32'h0, 32'h4,     1'b1, 1'b1, 1'b1, 32'h3000);
      // Conditional branches, adder holds operand1 minus operand2
      add_br(ex_pkg::BRU_BEQ,  32'h5, 32'h5, 32'h8, 1'b1, 1'b1, 1'b1, 32'h0);
      add_br(ex_pkg::BRU_BEQ,  32'h5, 32'h6, 32'h8, 1'b0, 1'b0, 1'b1, 32'hffffffff);
      add_br(ex_pkg::BRU_BNE,  32'h5, 32'h6, 32'h8, 1'b1, 1'b0, 1'b1, 32'hffffffff);
      add_br(ex_pkg::BRU_BNE,  32'h7, 32'h7, 32'h8, 1'b0, 1'b1, 1'b1, 32'h0);
      add_br(ex_pkg::BRU_BLT,  32'hffffffff, 32'h1, 32'h40, 1'b1, 1'b1, 1'b1, 32'hfffffffe);
      add_br(ex_pkg::BRU_BLT,  32'h1, 32'hffffffff, 32'h40, 1'b0, 1'b0, 1'b1, 32'h2);
      add_br(ex_pkg::BRU_BGE,  32'h2, 32'h1, 32'h40, 1'b1, 1'b0, 1'b1, 32'h1);
      // Signed overflow in the compare
      add_br(ex_pkg::BRU_BGE,  32'h80000000, 32'h7fffffff, 32'h40, 1'b0, 1'b0, 1'b1, 32'h1);
      add_br(ex_pkg::BRU_BLTU, 32'h1, 32'hffffffff, 32'h40, 1'b1, 1'b1, 1'b1, 32'h2);
      add_br(ex_pkg::BRU_BLTU, 32'hffffffff, 32'h1, 32'h40, 1'b0, 1'b0, 1'b1, 32'hfffffffe);
      add_br(ex_pkg::BRU_BGEU, 32'hffffffff, 32'h1, 32'h40, 1'b1, 1'b1, 1'b0, 32'hfffffffe);
      add_br(ex_pkg::BRU_BGEU, 32'h1, 32'hffffffff, 32'h40, 1'b0, 1'b0, 1'b1, 32'h2);
      // Address generation and fetch faults
      add_mem(ex_pkg::FU_LSU, 32'h2000, 32'h34, 32'h99, 3'h0, 32'h2034);
      add_mem(ex_pkg::FU_EPU, 32'h10, 32'hfffffff0, 32'h1, 3'h0, 32'h0);
      add_mem(ex_pkg::FU_LSU, 32'h100, 32'h4, 32'h2, 3'h3, 32'h104);
      add_mem(ex_pkg::FU_EPU, 32'h8, 32'h8, 32'h3, 3'h7, 32'h10);
   endtask

   // Streams the table, results checked in order and held while stalled
   task automatic run_table(input logic rand_ready);
      int             sent;
      int             got;
      int             guard;
      logic           stalled;
      ex_pkg::ex_wb_t held;
      sent    = 0;
      got     = 0;
      guard   = 0;
      stalled = 1'b0;
      held    = '0;
      while (got < rows.size()) begin
         @(negedge clk);
         if (stalled) begin
            check_bit(wb_valid, 1'b1, "valid held under stall");
            check_wb(wb, held, "wb held under stall");
         end
         if (rand_ready) begin
            lcg_state = lcg_next(lcg_state);
            wb_ready  = lcg_state[20];
         end else begin
            wb_ready = 1'b1;
         end
         ex_valid = (sent < rows.size());
         if (ex_valid) begin
            ex_issue = rows[sent].iss;
         end
         #1;
         // Stage holds whatever was taken and not yet drained
         check_bit(wb_valid, sent > got, "stage occupancy");
         if (wb_valid && wb_ready) begin
            check_wb(wb, rows[got].exp, $sformatf("table row %0d", got));
            got++;
         end
         stalled = wb_valid && !wb_ready;
         held    = wb;
         if (ex_valid && ex_ready) begin
            sent++;
         end
         guard++;
         if (guard > TIMEOUT) begin
            timed_out("table results");
         end
      end
      ex_valid = 1'b0;
   endtask

   task automatic send_one(input int idx);
      int guard;
      guard = 0;
      @(negedge clk);
      ex_valid = 1'b1;
      ex_issue = rows[idx].iss;
      wb_ready = 1'b1;
      #1;
      while (!ex_ready) begin
         guard++;
         if (guard > TIMEOUT) begin
            timed_out("issue accept");
         end
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      ex_valid = 1'b0;
      guard    = 0;
      #1;
      while (!wb_valid) begin
         guard++;
         if (guard > TIMEOUT) begin
            timed_out("single result");
         end
         @(negedge clk);
         #1;
      end
      check_wb(wb, rows[idx].exp, "single op");
   endtask

   // Two-cycle access, no wait states
   task automatic apb_access(input logic wr, input logic [`EX_APB_AW-1:0] addr,
      input ex_pkg::data_t wdata, output ex_pkg::data_t rdata, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #1;
      check_bit(pready, 1'b1, "pready in access phase");
      rdata = prdata;
      err   = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   // Read data only checked on a good read
   task automatic apb_check(input logic wr, input logic [`EX_APB_AW-1:0] addr,
      input ex_pkg::data_t wdata, input ex_pkg::data_t exp_rd, input logic exp_err,
      input string what);
      ex_pkg::data_t rd;
      logic          err;
      apb_access(wr, addr, wdata, rd, err);
      check_bit(err, exp_err, {what, " pslverr"});
      if (!wr && !exp_err) begin
         check_data(rd, exp_rd, what);
      end
   endtask

   initial begin : main
      int            n_fls;
      int            n_exc;
      ex_pkg::data_t n_ret;
      rst_n     = 1'b0;
      flush     = 1'b0;
      ex_valid  = 1'b0;
      ex_issue  = '0;
      wb_ready  = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      lcg_state = 32'hab5a;
      n_fls     = 0;
      n_exc     = 0;
      build_table();
      foreach (rows[i]) begin
         n_fls += int'(rows[i].exp.fls);
         n_exc += int'(rows[i].exp.exc);
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      #1;
      check_bit(wb_valid, 1'b0, "wb_valid after reset");
      check_bit(ex_ready, 1'b1, "ex_ready after reset");
      apb_check(1'b0, 4'h4, '0, 32'h0, 1'b0, "retire count after reset");

      // Full rate, then random back-pressure
      run_table(1'b0);
      run_table(1'b1);

      // Op taken just before flush never reaches writeback
      @(negedge clk);
      wb_ready = 1'b1;
      ex_valid = 1'b1;
      ex_issue = rows[0].iss;
      @(negedge clk);
      ex_issue = rows[1].iss;
      flush    = 1'b1;
      wb_ready = 1'b0;
      #1;
      check_bit(wb_valid, 1'b1, "op in stage before flush");
      @(negedge clk);
      // Empty stage, issue during flush is dropped
      wb_ready = 1'b1;
      #1;
      check_bit(wb_valid, 1'b0, "stage after flush");
      check_bit(ex_ready, 1'b1, "ready during flush");
      @(negedge clk);
      flush    = 1'b0;
      ex_valid = 1'b0;
      #1;
      check_bit(wb_valid, 1'b0, "issue under flush");

      n_ret = ex_pkg::data_t'(2 * rows.size());
      apb_check(1'b0, 4'h4, '0, n_ret, 1'b0, "retire count");
      apb_check(1'b0, 4'h8, '0, ex_pkg::data_t'(2 * n_fls), 1'b0, "flush count");
      apb_check(1'b0, 4'hc, '0, ex_pkg::data_t'(2 * n_exc), 1'b0, "exception count");

      // Halt blocks issue until cleared
      apb_check(1'b1, 4'h0, 32'h1, '0, 1'b0, "halt set");
      apb_check(1'b0, 4'h0, '0, 32'h1, 1'b0, "ctrl readback");
      @(negedge clk);
      ex_valid = 1'b1;
      ex_issue = rows[0].iss;
      for (int i = 0; i < 5; i++) begin
         #1;
         check_bit(ex_ready, 1'b0, "ready under halt");
         check_bit(wb_valid, 1'b0, "no result under halt");
         @(negedge clk);
      end
      ex_valid = 1'b0;
      apb_check(1'b1, 4'h0, 32'h0, '0, 1'b0, "halt clear");
      send_one(12);

      // Jal with a missed prediction adds one flush
      apb_check(1'b0, 4'h4, '0, n_ret + 1, 1'b0, "retire count after resume");
      apb_check(1'b0, 4'h8, '0, ex_pkg::data_t'(2 * n_fls + 1), 1'b0, "flush count after resume");
      apb_check(1'b1, 4'h4, 32'hffff, '0, 1'b0, "retire clear");
      apb_check(1'b0, 4'h4, '0, 32'h0, 1'b0, "retire count cleared");
      apb_check(1'b1, 4'hc, 32'h0, '0, 1'b0, "exception clear");
      apb_check(1'b0, 4'hc, '0, 32'h0, 1'b0, "exception count cleared");
      apb_check(1'b0, 4'h8, '0, ex_pkg::data_t'(2 * n_fls + 1), 1'b0, "flush count kept");

      // Misaligned address, no effect on halt
      apb_check(1'b1, 4'h1, 32'h1, '0, 1'b1, "unaligned write");
      apb_check(1'b0, 4'h0, '0, 32'h0, 1'b0, "ctrl after bad write");
      apb_check(1'b0, 4'h6, '0, '0, 1'b1, "unaligned read");

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/ex_tb_clk.sv
/*
 Testbench clock generator
 Free-running clock, 8 ns period
*/
`timescale 1ns/1ns
`default_nettype none

module ex_tb_clk #(
   parameter int HALF_NS = 4
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   always #HALF_NS clk = ~clk;

endmodule

`default_nettype wire
